//--- decode_pkg.sv
// Shared definitions for the RV32I decode stage
// Data and register-address widths, major opcodes,
// micro-op encodings and operand select codes

package decode_pkg;

    parameter int xlen       = 32;
    parameter int reg_addr_w = 5;

    // Major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } major_op_t;

    // ------------------------------
    // Execute micro-ops
    // ------------------------------

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
    } alu_op_t;

    typedef enum logic [3:0] {
        LSU_NONE, LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW,
        LSU_SB,   LSU_SH, LSU_SW
    } lsu_op_t;

    typedef enum logic [3:0] {
        CFU_NONE, CFU_BEQ,  CFU_BNE,  CFU_BLT, CFU_BGE,
        CFU_BLTU, CFU_BGEU, CFU_JAL,  CFU_JALR
    } cfu_op_t;

    // ------------------------------
    // Operand selects
    // ------------------------------

    typedef enum logic [1:0] {
        OPR_A_ZERO, OPR_A_RS1, OPR_A_PC
    } opr_a_sel_t;

    typedef enum logic [1:0] {
        OPR_B_ZERO, OPR_B_RS2, OPR_B_IMM
    } opr_b_sel_t;

    typedef enum logic [1:0] {
        OPR_C_ZERO, OPR_C_RS2, OPR_C_IMM, OPR_C_NPC
    } opr_c_sel_t;

    // Which immediate format feeds operand B / C
    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_t;

endpackage

//--- decode_immediates.sv
// RV32I immediate extraction
// I, S, B, U and J formats, sign-extended to XLEN

`timescale 1ns/1ps

module decode_immediates #(
    parameter int XLEN = decode_pkg::xlen
) (
    input  logic [31:0]     instr,
    output logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] imm_s,
    output logic [XLEN-1:0] imm_b,
    output logic [XLEN-1:0] imm_u,
    output logic [XLEN-1:0] imm_j
);

    // 32-bit forms, widened below
    logic signed [31:0] imm32_i;
    logic signed [31:0] imm32_s;
    logic signed [31:0] imm32_b;
    logic signed [31:0] imm32_u;
    logic signed [31:0] imm32_j;

    assign imm32_i = {{20{instr[31]}}, instr[31:20]};
    assign imm32_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // Branch offset, bit 0 always clear
    assign imm32_b = {{19{instr[31]}}, instr[31], instr[7],
                      instr[30:25], instr[11:8], 1'b0};

    assign imm32_u = {instr[31:12], 12'b0};   // Upper 20 bits only

    // Jump offset, +/- 1 MiB
    assign imm32_j = {{11{instr[31]}}, instr[31], instr[19:12],
                      instr[20], instr[30:21], 1'b0};

    // Sign-extend to the data width
    assign imm_i = XLEN'(imm32_i);
    assign imm_s = XLEN'(imm32_s);
    assign imm_b = XLEN'(imm32_b);
    assign imm_u = XLEN'(imm32_u);
    assign imm_j = XLEN'(imm32_j);

endmodule

//--- decode_uop.sv
// Micro-op decode for RV32I
// Major opcode plus funct3 / funct7[5] to ALU, LSU and CFU ops,
// operand selects, immediate select and register addresses

`timescale 1ns/1ps

module decode_uop (
    input  logic [31:0]                      instr,
    output logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rd,
    output decode_pkg::alu_op_t              alu_op,
    output decode_pkg::lsu_op_t              lsu_op,
    output decode_pkg::cfu_op_t              cfu_op,
    output decode_pkg::opr_a_sel_t           sel_a,
    output decode_pkg::opr_b_sel_t           sel_b,
    output decode_pkg::opr_c_sel_t           sel_c,
    output decode_pkg::imm_sel_t             imm_sel,
    output logic                             is_jal
);

    import decode_pkg::*;

    major_op_t  opc;
    logic [2:0] funct3;
    logic       f7b5;

    assign opc    = major_op_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign f7b5   = instr[30];          // SUB / SRA modifier

    // Register reads always follow the raw fields
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign is_jal = (opc == OPC_JAL);

    // Shared OP / OP_IMM arithmetic decode
    function automatic alu_op_t f3_alu(input logic [2:0] f3, input logic sub,
                                       input logic sra);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        // Unknown opcodes fall through as a full NOP
        alu_op  = ALU_NOP;
        lsu_op  = LSU_NONE;
        cfu_op  = CFU_NONE;
        sel_a   = OPR_A_ZERO;
        sel_b   = OPR_B_ZERO;
        sel_c   = OPR_C_ZERO;
        imm_sel = IMM_NONE;
        rd      = '0;

        case (opc)
            OPC_OP: begin
                alu_op = f3_alu(funct3, f7b5, f7b5);
                sel_a  = OPR_A_RS1;
                sel_b  = OPR_B_RS2;
                rd     = instr[11:7];
            end
            OPC_OP_IMM: begin
                alu_op  = f3_alu(funct3, 1'b0, f7b5);    // No SUBI
                sel_a   = OPR_A_RS1;
                sel_b   = OPR_B_IMM;
                imm_sel = IMM_I;
                rd      = instr[11:7];
            end
            OPC_LOAD: begin
                alu_op  = ALU_ADD;                       // Address calc
                sel_a   = OPR_A_RS1;
                sel_b   = OPR_B_IMM;
                imm_sel = IMM_I;
                rd      = instr[11:7];
                case (funct3)
                    3'b000:  lsu_op = LSU_LB;
                    3'b001:  lsu_op = LSU_LH;
                    3'b010:  lsu_op = LSU_LW;
                    3'b100:  lsu_op = LSU_LBU;
                    3'b101:  lsu_op = LSU_LHU;
                    default: lsu_op = LSU_NONE;
                endcase
            end
            OPC_STORE: begin
                alu_op  = ALU_ADD;
                sel_a   = OPR_A_RS1;
                sel_b   = OPR_B_IMM;
                sel_c   = OPR_C_RS2;                     // Store data
                imm_sel = IMM_S;
                case (funct3)
                    3'b000:  lsu_op = LSU_SB;
                    3'b001:  lsu_op = LSU_SH;
                    3'b010:  lsu_op = LSU_SW;
                    default: lsu_op = LSU_NONE;
                endcase
            end
            OPC_BRANCH: begin
                alu_op  = ALU_SUB;                       // Compare
                sel_a   = OPR_A_RS1;
                sel_b   = OPR_B_RS2;
                sel_c   = OPR_C_IMM;                     // Branch offset
                imm_sel = IMM_B;
                case (funct3)
                    3'b000:  cfu_op = CFU_BEQ;
                    3'b001:  cfu_op = CFU_BNE;
                    3'b100:  cfu_op = CFU_BLT;
                    3'b101:  cfu_op = CFU_BGE;
                    3'b110:  cfu_op = CFU_BLTU;
                    3'b111:  cfu_op = CFU_BGEU;
                    default: cfu_op = CFU_NONE;
                endcase
            end
            OPC_LUI: begin
                alu_op  = ALU_OR;                        // 0 | imm
                sel_b   = OPR_B_IMM;
                imm_sel = IMM_U;
                rd      = instr[11:7];
            end
            OPC_AUIPC: begin
                alu_op  = ALU_ADD;
                sel_a   = OPR_A_PC;
                sel_b   = OPR_B_IMM;
                imm_sel = IMM_U;
                rd      = instr[11:7];
            end
            OPC_JAL: begin
                cfu_op  = CFU_JAL;
                sel_a   = OPR_A_PC;
                sel_b   = OPR_B_IMM;
                sel_c   = OPR_C_NPC;                     // Link value
                imm_sel = IMM_J;
                rd      = instr[11:7];
            end
            OPC_JALR: begin
                cfu_op  = CFU_JALR;
                sel_a   = OPR_A_RS1;
                sel_b   = OPR_B_IMM;
                sel_c   = OPR_C_NPC;
                imm_sel = IMM_I;
                rd      = instr[11:7];
            end
            default: ;
        endcase
    end

endmodule

//--- decode_operands.sv
// Execute operand selection
// Operands A, B and C from register data, PC, next PC
// and the immediate picked by the decoder

`timescale 1ns/1ps

module decode_operands #(
    parameter int XLEN = decode_pkg::xlen
) (
    input  logic [XLEN-1:0]        pc,
    input  logic [XLEN-1:0]        rs1_data,
    input  logic [XLEN-1:0]        rs2_data,
    input  logic [XLEN-1:0]        imm_i,
    input  logic [XLEN-1:0]        imm_s,
    input  logic [XLEN-1:0]        imm_b,
    input  logic [XLEN-1:0]        imm_u,
    input  logic [XLEN-1:0]        imm_j,
    input  decode_pkg::opr_a_sel_t sel_a,
    input  decode_pkg::opr_b_sel_t sel_b,
    input  decode_pkg::opr_c_sel_t sel_c,
    input  decode_pkg::imm_sel_t   imm_sel,
    output logic [XLEN-1:0]        opr_a,
    output logic [XLEN-1:0]        opr_b,
    output logic [XLEN-1:0]        opr_c
);

    import decode_pkg::*;

    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] npc;

    assign npc = pc + XLEN'(4);         // No compressed, always +4

    // Immediate shared by operand B and C paths
    always_comb begin
        case (imm_sel)
            IMM_I:   imm = imm_i;
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = '0;
        endcase
    end

    always_comb begin
        case (sel_a)
            OPR_A_RS1: opr_a = rs1_data;
            OPR_A_PC:  opr_a = pc;
            default:   opr_a = '0;
        endcase

        case (sel_b)
            OPR_B_RS2: opr_b = rs2_data;
            OPR_B_IMM: opr_b = imm;
            default:   opr_b = '0;
        endcase

        case (sel_c)
            OPR_C_RS2: opr_c = rs2_data;   // Store data
            OPR_C_IMM: opr_c = imm;        // Branch offset
            OPR_C_NPC: opr_c = npc;        // Link address
            default:   opr_c = '0;
        endcase
    end

endmodule

//--- decode_pipe_reg.sv
// Decode stage progression and decode-to-execute register
// Fetch eat, JAL control-flow request with ack wait,
// valid/ready hold of the execute fields

`timescale 1ns/1ps

module decode_pipe_reg #(
    parameter int XLEN = decode_pkg::xlen
) (
    input  logic                              g_clk,
    input  logic                              rst,
    input  logic                              fetch_valid,
    input  logic [XLEN-1:0]                   fetch_pc,
    input  logic                              is_jal,
    input  logic                              cf_ack,
    input  logic                              s2_ready,
    input  logic [XLEN-1:0]                   imm_j,
    input  logic [XLEN-1:0]                   opr_a,
    input  logic [XLEN-1:0]                   opr_b,
    input  logic [XLEN-1:0]                   opr_c,
    input  logic [decode_pkg::reg_addr_w-1:0] rd,
    input  decode_pkg::alu_op_t               alu_op,
    input  decode_pkg::lsu_op_t               lsu_op,
    input  decode_pkg::cfu_op_t               cfu_op,
    output logic                              eat,
    output logic                              cf_valid,
    output logic [XLEN-1:0]                   cf_target,
    output logic                              s2_valid,
    output logic [XLEN-1:0]                   s2_pc,
    output logic [XLEN-1:0]                   s2_opr_a,
    output logic [XLEN-1:0]                   s2_opr_b,
    output logic [XLEN-1:0]                   s2_opr_c,
    output logic [decode_pkg::reg_addr_w-1:0] s2_rd,
    output decode_pkg::alu_op_t               s2_alu_op,
    output decode_pkg::lsu_op_t               s2_lsu_op,
    output decode_pkg::cfu_op_t               s2_cfu_op
);

    import decode_pkg::*;

    logic s2_free;      // Register empty or draining this cycle
    logic cf_wait;      // JAL still waiting on its ack

    // ------------------------------
    // Control flow request
    // ------------------------------

    assign cf_valid  = fetch_valid && is_jal;
    assign cf_target = fetch_pc + imm_j;
    assign cf_wait   = is_jal && !cf_ack;

    // ------------------------------
    // Stage progression
    // ------------------------------

    assign s2_free = !s2_valid || s2_ready;
    assign eat     = fetch_valid && !cf_wait && s2_free;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s2_valid  <= 1'b0;
            s2_pc     <= '0;
            s2_opr_a  <= '0;
            s2_opr_b  <= '0;
            s2_opr_c  <= '0;
            s2_rd     <= '0;
            s2_alu_op <= ALU_NOP;
            s2_lsu_op <= LSU_NONE;
            s2_cfu_op <= CFU_NONE;
        end else if (eat) begin
            s2_valid  <= 1'b1;
            s2_pc     <= fetch_pc;
            s2_opr_a  <= opr_a;
            s2_opr_b  <= opr_b;
            s2_opr_c  <= opr_c;
            s2_rd     <= rd;
            s2_alu_op <= alu_op;
            s2_lsu_op <= lsu_op;
            s2_cfu_op <= cfu_op;
        end else if (s2_ready) begin
            s2_valid  <= 1'b0;   // Drained, nothing new behind it
        end
    end

endmodule

//--- core_decode.sv
// Decode and operand-gather stage top level
// Immediates, micro-op decode, operand select and pipeline register

`timescale 1ns/1ps

module core_decode #(
    parameter int XLEN = decode_pkg::xlen
) (
    input  logic                              g_clk,
    input  logic                              rst,

    input  logic                              fetch_valid,
    input  logic [31:0]                       fetch_instr,
    input  logic [XLEN-1:0]                   fetch_pc,
    output logic                              eat,

    output logic                              cf_valid,
    output logic [XLEN-1:0]                   cf_target,
    input  logic                              cf_ack,

    output logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [XLEN-1:0]                   rs1_data,
    output logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [XLEN-1:0]                   rs2_data,

    output logic                              s2_valid,
    input  logic                              s2_ready,
    output logic [XLEN-1:0]                   s2_pc,
    output logic [XLEN-1:0]                   s2_opr_a,
    output logic [XLEN-1:0]                   s2_opr_b,
    output logic [XLEN-1:0]                   s2_opr_c,
    output logic [decode_pkg::reg_addr_w-1:0] s2_rd,
    output decode_pkg::alu_op_t               s2_alu_op,
    output decode_pkg::lsu_op_t               s2_lsu_op,
    output decode_pkg::cfu_op_t               s2_cfu_op
);

    // Immediates
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Decoded micro-op
    logic [decode_pkg::reg_addr_w-1:0] rd;
    decode_pkg::alu_op_t               alu_op;
    decode_pkg::lsu_op_t               lsu_op;
    decode_pkg::cfu_op_t               cfu_op;
    decode_pkg::opr_a_sel_t            sel_a;
    decode_pkg::opr_b_sel_t            sel_b;
    decode_pkg::opr_c_sel_t            sel_c;
    decode_pkg::imm_sel_t              imm_sel;
    logic                              is_jal;

    // Gathered operands
    logic [XLEN-1:0] opr_a;
    logic [XLEN-1:0] opr_b;
    logic [XLEN-1:0] opr_c;

    // ------------------------------
    // Stage instances
    // ------------------------------

    decode_immediates #(.XLEN(XLEN)) decode_immediates_i (
        .instr (fetch_instr),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_b (imm_b),
        .imm_u (imm_u),
        .imm_j (imm_j)
    );

    decode_uop decode_uop_i (
        .instr    (fetch_instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd       (rd),
        .alu_op   (alu_op),
        .lsu_op   (lsu_op),
        .cfu_op   (cfu_op),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .sel_c    (sel_c),
        .imm_sel  (imm_sel),
        .is_jal   (is_jal)
    );

    decode_operands #(.XLEN(XLEN)) decode_operands_i (
        .pc       (fetch_pc),
        .rs1_data (rs1_data),      // Same-cycle regfile read
        .rs2_data (rs2_data),
        .imm_i    (imm_i),
        .imm_s    (imm_s),
        .imm_b    (imm_b),
        .imm_u    (imm_u),
        .imm_j    (imm_j),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .sel_c    (sel_c),
        .imm_sel  (imm_sel),
        .opr_a    (opr_a),
        .opr_b    (opr_b),
        .opr_c    (opr_c)
    );

    decode_pipe_reg #(.XLEN(XLEN)) decode_pipe_reg_i (
        .g_clk       (g_clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .is_jal      (is_jal),
        .cf_ack      (cf_ack),
        .s2_ready    (s2_ready),
        .imm_j       (imm_j),
        .opr_a       (opr_a),
        .opr_b       (opr_b),
        .opr_c       (opr_c),
        .rd          (rd),
        .alu_op      (alu_op),
        .lsu_op      (lsu_op),
        .cfu_op      (cfu_op),
        .eat         (eat),
        .cf_valid    (cf_valid),
        .cf_target   (cf_target),
        .s2_valid    (s2_valid),
        .s2_pc       (s2_pc),
        .s2_opr_a    (s2_opr_a),
        .s2_opr_b    (s2_opr_b),
        .s2_opr_c    (s2_opr_c),
        .s2_rd       (s2_rd),
        .s2_alu_op   (s2_alu_op),
        .s2_lsu_op   (s2_lsu_op),
        .s2_cfu_op   (s2_cfu_op)
    );

endmodule

//--- tb_decode_model.svh
// Reference model for the decode stage testbench
// Expected-result record, register-file values, RV32I decode rules
// and the Galois LFSR used for random stimulus

`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

typedef struct packed {
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] target;        // JAL target, checked at fetch
    logic [4:0]  rd;
    logic [3:0]  alu;
    logic [3:0]  lsu;
    logic [3:0]  cfu;
} exp_t;

logic [31:0] lfsr_state = 32'h1;

// One bit per step, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        lsb;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
        lsb         = lfsr_state[0];
        v           = {v[30:0], lsb};
        lfsr_state  = lfsr_state >> 1;
        if (lsb) lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return v;
endfunction

// Register file contents seen by the decode stage
function automatic logic [31:0] rf_value(input logic [4:0] addr);
    return (addr == 5'd0) ? 32'h0 : 32'(addr) * 32'h9E3779B1;
endfunction

// ------------------------------
// ALU op from funct3
// ------------------------------
function automatic logic [3:0] alu_for(input logic [2:0] f3, input logic alt,
                                       input logic reg_form);
    case (f3)
        3'd0:    return (alt && reg_form) ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic exp_t model_decode(input logic [31:0] instr, input logic [31:0] pc);
    exp_t        e;
    logic [31:0] ii;
    logic [31:0] is;
    logic [31:0] ib;
    logic [31:0] iu;
    logic [31:0] ij;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [2:0]  f3;
    logic        alt;
    ii  = $signed(instr) >>> 20;
    is  = {ii[31:5], instr[11:7]};                 // S swaps the low five bits
    ib  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    iu  = {instr[31:12], 12'h000};
    ij  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    r1  = rf_value(instr[19:15]);
    r2  = rf_value(instr[24:20]);
    f3  = instr[14:12];
    alt = instr[30];
    e        = '0;
    e.pc     = pc;
    e.target = pc + ij;
    case (instr[6:0])
        7'b0110011: begin               // OP
            e.alu = alu_for(f3, alt, 1'b1);
            e.a   = r1;
            e.b   = r2;
            e.rd  = instr[11:7];
        end
        7'b0010011: begin               // OP_IMM
            e.alu = alu_for(f3, alt, 1'b0);
            e.a   = r1;
            e.b   = ii;
            e.rd  = instr[11:7];
        end
        7'b0000011: begin               // LOAD
            e.alu = ALU_ADD;
            e.a   = r1;
            e.b   = ii;
            e.rd  = instr[11:7];
            case (f3)
                3'd0:    e.lsu = LSU_LB;
                3'd1:    e.lsu = LSU_LH;
                3'd2:    e.lsu = LSU_LW;
                3'd4:    e.lsu = LSU_LBU;
                3'd5:    e.lsu = LSU_LHU;
                default: e.lsu = LSU_NONE;
            endcase
        end
        7'b0100011: begin               // STORE
            e.alu = ALU_ADD;
            e.a   = r1;
            e.b   = is;
            e.c   = r2;
            case (f3)
                3'd0:    e.lsu = LSU_SB;
                3'd1:    e.lsu = LSU_SH;
                3'd2:    e.lsu = LSU_SW;
                default: e.lsu = LSU_NONE;
            endcase
        end
        7'b1100011: begin               // BRANCH
            e.alu = ALU_SUB;
            e.a   = r1;
            e.b   = r2;
            e.c   = ib;
            case (f3)
                3'd0:    e.cfu = CFU_BEQ;
                3'd1:    e.cfu = CFU_BNE;
                3'd4:    e.cfu = CFU_BLT;
                3'd5:    e.cfu = CFU_BGE;
                3'd6:    e.cfu = CFU_BLTU;
                3'd7:    e.cfu = CFU_BGEU;
                default: e.cfu = CFU_NONE;
            endcase
        end
        7'b0110111: begin               // LUI
            e.alu = ALU_OR;
            e.b   = iu;
            e.rd  = instr[11:7];
        end
        7'b0010111: begin               // AUIPC
            e.alu = ALU_ADD;
            e.a   = pc;
            e.b   = iu;
            e.rd  = instr[11:7];
        end
        7'b1101111: begin               // JAL
            e.cfu = CFU_JAL;
            e.a   = pc;
            e.b   = ij;
            e.c   = pc + 32'd4;
            e.rd  = instr[11:7];
        end
        7'b1100111: begin               // JALR
            e.cfu = CFU_JALR;
            e.a   = r1;
            e.b   = ii;
            e.c   = pc + 32'd4;
            e.rd  = instr[11:7];
        end
        default: ;                      // Everything else is a NOP
    endcase
    return e;
endfunction

`endif

//--- tb_core_decode.sv
// Testbench for the RV32I decode stage
// Clock and reset, fetch and execute stimulus, register-file model,
// expected-result queue with scoreboard, closing report

`timescale 1ns/1ps

module tb_core_decode;

    import decode_pkg::*;

    logic        g_clk;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] fetch_instr;
    logic [31:0] fetch_pc;
    logic        eat;
    logic        cf_valid;
    logic [31:0] cf_target;
    logic        cf_ack;
    logic [4:0]  rs1_addr;
    logic [31:0] rs1_data;
    logic [4:0]  rs2_addr;
    logic [31:0] rs2_data;
    logic        s2_valid;
    logic        s2_ready;
    logic [31:0] s2_pc;
    logic [31:0] s2_opr_a;
    logic [31:0] s2_opr_b;
    logic [31:0] s2_opr_c;
    logic [4:0]  s2_rd;
    alu_op_t     s2_alu_op;
    lsu_op_t     s2_lsu_op;
    cfu_op_t     s2_cfu_op;

    `include "tb_decode_model.svh"

    exp_t        exp_q[$];
    int          errors = 0;
    int          timeouts = 0;
    int          issued = 0;
    logic        random_ready = 1'b0;
    logic        eat_q = 1'b0;
    logic [31:0] next_pc = 32'h0000_1000;

    core_decode #(.XLEN(32)) core_decode_i (.*);

    assign rs1_data = rf_value(rs1_addr);       // Same-cycle read
    assign rs2_data = rf_value(rs2_addr);

    always #20 g_clk = ~g_clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // ------------------------------
    // Scoreboard
    // ------------------------------
    always @(posedge g_clk) begin : scoreboard
        exp_t e;
        if (rst) begin
            eat_q = 1'b0;
        end else begin
            if (eat_q) check_value("s2_valid after eat", 32'(s2_valid), 32'h1);
            if (s2_valid && !s2_ready) check_value("eat while stalled", 32'(eat), 32'h0);
            if (s2_valid && s2_ready) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t: transfer with no instruction expected", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_value("s2_pc", s2_pc, e.pc);
                    check_value("s2_opr_a", s2_opr_a, e.a);
                    check_value("s2_opr_b", s2_opr_b, e.b);
                    check_value("s2_opr_c", s2_opr_c, e.c);
                    check_value("s2_rd", 32'(s2_rd), 32'(e.rd));
                    check_value("s2_alu_op", 32'(s2_alu_op), 32'(e.alu));
                    check_value("s2_lsu_op", 32'(s2_lsu_op), 32'(e.lsu));
                    check_value("s2_cfu_op", 32'(s2_cfu_op), 32'(e.cfu));
                end
            end
            if (eat) exp_q.push_back(model_decode(fetch_instr, fetch_pc));
            eat_q = eat;
        end
    end

    // Random instruction of one class
    // Kind 9 gives an unknown opcode
    function automatic logic [31:0] random_instr(input int kind);
        logic [31:0] w;
        logic [31:0] r;
        logic [2:0]  f3;
        w  = rand_bits(32);
        r  = rand_bits(3);
        f3 = r[2:0];
        case (kind)
            0: w[31:25] = {1'b0, w[30], 5'b0};
            1: if (f3 == 3'd1 || f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
            2: if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'd2;
            3: f3 = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
            4: if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4;
            8: f3 = 3'd0;
            default: ;
        endcase
        case (kind)
            0:       w[6:0] = 7'b0110011;
            1:       w[6:0] = 7'b0010011;
            2:       w[6:0] = 7'b0000011;
            3:       w[6:0] = 7'b0100011;
            4:       w[6:0] = 7'b1100011;
            5:       w[6:0] = 7'b0110111;
            6:       w[6:0] = 7'b0010111;
            7:       w[6:0] = 7'b1101111;
            8:       w[6:0] = 7'b1100111;
            default: begin
                case (f3[1:0])
                    2'd0:    w[6:0] = 7'b0001111;    // fence
                    2'd1:    w[6:0] = 7'b1110011;    // system
                    2'd2:    w[6:0] = 7'b0000000;
                    default: w[6:0] = 7'b1111111;
                endcase
            end
        endcase
        if (kind < 5 || kind == 8) w[14:12] = f3;    // U and J keep the random bits
        return w;
    endfunction

    // Present one instruction at a falling edge
    task automatic drive_instr(input logic [31:0] instr);
        exp_t        e;
        int          waited;
        int          ack_delay;
        logic        jal;
        logic        done;
        logic [31:0] r;
        if (timeouts != 0) return;
        e         = model_decode(instr, next_pc);
        jal       = (instr[6:0] == 7'b1101111);
        r         = rand_bits(2);
        ack_delay = jal ? int'(r[1:0]) : 0;
        fetch_valid = 1'b1;
        fetch_instr = instr;
        fetch_pc    = next_pc;
        waited      = 0;
        done        = 1'b0;
        while (!done && timeouts == 0) begin
            cf_ack = jal && (ack_delay == 0);
            if (random_ready) begin
                r        = rand_bits(1);
                s2_ready = r[0];
            end else begin
                s2_ready = 1'b1;
            end
            @(posedge g_clk);
            done = eat;
            check_value("cf_valid", 32'(cf_valid), 32'(jal));
            check_value("rs1_addr", 32'(rs1_addr), 32'(instr[19:15]));
            check_value("rs2_addr", 32'(rs2_addr), 32'(instr[24:20]));
            if (jal) begin
                check_value("cf_target", cf_target, e.target);
                check_value("eat without cf_ack", 32'(eat && !cf_ack), 32'h0);
            end
            @(negedge g_clk);
            if (ack_delay > 0) ack_delay--;
            waited++;
            if (!done && waited > 100) begin
                $display("Timeout: instruction %h was not consumed in 100 cycles", instr);
                timeouts++;
            end
        end
        issued++;
        next_pc     = next_pc + 32'd4;
        fetch_valid = 1'b0;
        cf_ack      = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited      = 0;
        fetch_valid = 1'b0;
        s2_ready    = 1'b1;
        while ((s2_valid || exp_q.size() != 0) && timeouts == 0) begin
            @(negedge g_clk);
            waited++;
            if (waited > 20) begin
                $display("Timeout: decode register did not drain in 20 cycles");
                timeouts++;
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main
        int          i;
        logic [31:0] r;
        g_clk       = 1'b0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_pc    = '0;
        cf_ack      = 1'b0;
        s2_ready    = 1'b0;
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        rst = 1'b0;

        // Register must come out of reset empty and cleared
        check_value("reset s2_valid", 32'(s2_valid), 32'h0);
        check_value("reset s2_pc", s2_pc, 32'h0);
        check_value("reset s2_opr_a", s2_opr_a, 32'h0);
        check_value("reset s2_opr_b", s2_opr_b, 32'h0);
        check_value("reset s2_opr_c", s2_opr_c, 32'h0);
        check_value("reset s2_rd", 32'(s2_rd), 32'h0);
        check_value("reset s2_alu_op", 32'(s2_alu_op), 32'(ALU_NOP));
        check_value("reset s2_lsu_op", 32'(s2_lsu_op), 32'(LSU_NONE));
        check_value("reset s2_cfu_op", 32'(s2_cfu_op), 32'(CFU_NONE));

        for (i = 0; i < 40; i++) begin      // OP and OP_IMM with ready held high
            r = rand_bits(1);
            drive_instr(random_instr(int'(r[0])));
        end
        drain();
        for (i = 0; i < 30; i++) begin      // Memory, upper-immediate, branch
            r = rand_bits(3);
            drive_instr(random_instr(2 + int'(r[2:0]) % 5));
        end
        drain();
        random_ready = 1'b1;
        for (i = 0; i < 80; i++) begin      // Mixed traffic with back-pressure
            r = rand_bits(4);
            drive_instr(random_instr(int'(r[3:0]) % 10));
        end
        drain();
        for (i = 0; i < 12; i++) begin
            r = rand_bits(1);
            drive_instr(random_instr(r[0] ? 7 : 8));
        end
        drain();
        for (i = 0; i < 8; i++) drive_instr(random_instr(9));
        drain();

        $display("Decode checks done: %0d instructions, %0d errors, %0d timeouts",
                 issued, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
decode_pkg.sv
decode_immediates.sv
decode_uop.sv
decode_operands.sv
decode_pipe_reg.sv
core_decode.sv
tb_core_decode.sv

//--- run.sh
#!/bin/bash
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_core_decode -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qxF '** PASS **' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
